// File: filelist.f
+incdir+.
zports_pkg.sv
port_decode.sv
config_regs.sv
sd_port.sv
port_read_mux.sv
zports_top.sv
tb_zports.sv

// File: zports_model.svh
// reference model and LFSR of the port block, included inside the testbench module
`ifndef ZPORTS_MODEL_SVH
`define ZPORTS_MODEL_SVH

logic [31:0] lfsr_state = 32'hd1ab_5865;

logic [7:0] m_page [0:3];
logic [7:0] m_sysconf;
logic [7:0] m_memconf;
logic [7:0] m_intmask;
logic [3:0] m_cacheconf;
logic [3:0] m_cs_n;
logic       m_lock48;
logic       m_fetch_lock;  // lock seen at the last opcode fetch
logic       m_pwr_up;
logic       m_pwr_bit;

// galois lfsr, one step for each bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++)
  begin
    bits = {bits[30:0], lfsr_state[0]};
    if (lfsr_state[0])
      lfsr_state = (lfsr_state >> 1) ^ 32'hD000_0001;
    else
      lfsr_state = lfsr_state >> 1;
  end
  return bits;
endfunction

function automatic void reset_model();
  m_page[0] = 8'h00;
  m_page[1] = 8'h05;
  m_page[2] = 8'h02;
  m_page[3] = 8'h00;
  m_sysconf = 8'h00;
  m_memconf = 8'h04;
  m_intmask = 8'h01;
  m_cacheconf = 4'h0;
  m_cs_n = 4'hF;  // all selects released
  m_lock48 = 1'b0;
  m_fetch_lock = 1'b0;
  m_pwr_up = 1'b1;
  m_pwr_bit = 1'b0;
endfunction

function automatic logic port_hit(input logic [7:0] lo);
  return lo == `ZP_PORT_FE || lo == `ZP_PORT_FD || lo == `ZP_PORT_XT ||
         lo == `ZP_PORT_SDCFG || lo == `ZP_PORT_SDDAT;
endfunction

function automatic logic [7:0] expect_dout(input logic [15:0] addr, input logic [4:0] keys,
                                           input logic tape, input logic [7:0] sd_in);
  case (addr[7:0])
    `ZP_PORT_FE:
      return {1'b1, tape, 1'b1, keys};
    `ZP_PORT_XT:
      if (addr[15:8] == `ZP_XT_XSTAT)
        return {1'b0, m_pwr_bit, 3'b000, `ZP_VDAC_VER};
      else if (addr[15:8] == `ZP_XT_RAMPAGE + 8'd2)
        return m_page[2];
      else if (addr[15:8] == `ZP_XT_RAMPAGE + 8'd3)
        return m_page[3];
      else
        return 8'hFF;
    `ZP_PORT_SDCFG:
      return 8'h00;
    `ZP_PORT_SDDAT:
      return sd_in;
    default:
      return 8'hFF;
  endcase
endfunction

// state change at one rising clk edge, all decisions on the old state
function automatic void update_model(input logic [15:0] addr, input logic [7:0] d,
                                     input logic wr_s, input logic rd_s, input logic fetch);
  logic [1:0] mode;
  logic       lock;
  logic [7:0] idx;
  mode = m_memconf[7:6];
  lock = (mode == 2'b10) ? m_fetch_lock : m_memconf[6];
  idx = addr[15:8] - `ZP_XT_RAMPAGE;
  if (addr[7:0] == `ZP_PORT_FD && !addr[15] && wr_s && !m_lock48)
  begin
    m_memconf[0] = d[4];
    if (mode == 2'b11)
      m_page[3] = {2'b00, d[5], d[7], d[6], d[2:0]};  // bit 5 is a page bit here
    else
    begin
      m_page[3] = {3'b000, lock ? 2'b00 : d[7:6], d[2:0]};
      m_lock48 = d[5];
    end
  end
  if (addr[7:0] == `ZP_PORT_XT && wr_s)
    case (addr[15:8])
      `ZP_XT_RAMPAGE, `ZP_XT_RAMPAGE + 8'd1, `ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3:
        m_page[idx[1:0]] = d;
      `ZP_XT_SYSCONF:
      begin
        m_sysconf = d;
        m_cacheconf = {4{d[2]}};
      end
      `ZP_XT_MEMCONF:
        m_memconf = d;
      `ZP_XT_INTMASK:
        m_intmask = d;
      `ZP_XT_CACHECONF:
        m_cacheconf = d[3:0];
      default: ;
    endcase
  if (addr[7:0] == `ZP_PORT_XT && rd_s && addr[15:8] == `ZP_XT_XSTAT)
  begin
    m_pwr_bit = m_pwr_up;
    m_pwr_up = 1'b0;
  end
  if (addr[7:0] == `ZP_PORT_SDCFG && wr_s)
    m_cs_n = {~d[4:2], d[1]};
  if (fetch)
    m_fetch_lock = (d[7] == d[6]);
endfunction

`endif

// File: tb_zports.sv
// testbench of the I/O port block; random port cycles checked against the reference model
`timescale 1ns/1ns
`default_nettype none
`include "zports_consts.svh"

module tb_zports;

  localparam int clk_period = 10;
  localparam int num_phases = 8;
  localparam int ops_per_phase = 300;
  localparam int num_ops = num_phases * (ops_per_phase + 6);

  logic        clk = 1'b0;
  logic        rst;
  logic [7:0]  din;
  logic [15:0] a;
  logic        iord;
  logic        iowr_s;
  logic        iord_s;
  logic        opfetch;
  logic        wr;
  logic [4:0]  keys_in;
  logic        tape_read;
  logic [7:0]  sd_dataout;
  logic [7:0]  dout;
  logic        porthit;
  logic        dataout;
  logic        beeper_wr;
  logic [31:0] xt_page;
  logic [7:0]  sysconf;
  logic [7:0]  memconf;
  logic [3:0]  cacheconf;
  logic [7:0]  intmask;
  logic [3:0]  spi_cs_n;
  logic        sd_start;
  logic [7:0]  sd_datain;

  int         fail_count = 0;
  logic [7:0] seen_dout;  // dout of the last cycle, for directed checks

  `include "zports_model.svh"

  zports_top dut_i (.clk(clk), .rst(rst), .din(din), .a(a), .iord(iord), .iowr_s(iowr_s),
    .iord_s(iord_s), .opfetch(opfetch), .wr(wr), .keys_in(keys_in), .tape_read(tape_read),
    .sd_dataout(sd_dataout), .dout(dout), .porthit(porthit), .dataout(dataout),
    .beeper_wr(beeper_wr), .xt_page(xt_page), .sysconf(sysconf), .memconf(memconf),
    .cacheconf(cacheconf), .intmask(intmask), .spi_cs_n(spi_cs_n), .sd_start(sd_start),
    .sd_datain(sd_datain));

  always #(clk_period / 2) clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      fail_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_registers();
    compare_value("xt_page", xt_page, {m_page[3], m_page[2], m_page[1], m_page[0]});
    compare_value("sysconf", sysconf, m_sysconf);
    compare_value("memconf", memconf, m_memconf);
    compare_value("cacheconf", cacheconf, m_cacheconf);
    compare_value("intmask", intmask, m_intmask);
    compare_value("spi_cs_n", spi_cs_n, m_cs_n);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    a = '0;
    din = '0;
    iord = 1'b0;
    iowr_s = 1'b0;
    iord_s = 1'b0;
    opfetch = 1'b0;
    wr = 1'b0;
    keys_in = '0;
    tape_read = 1'b0;
    sd_dataout = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    reset_model();
  endtask

  // entered just after a falling edge, returns after the next one
  task automatic run_cycle(input logic [15:0] addr, input logic [7:0] d, input logic wr_s,
                           input logic rd_s, input logic rd_lvl, input logic fetch,
                           input logic wr_lvl);
    a = addr;
    din = d;
    iowr_s = wr_s;
    iord_s = rd_s;
    iord = rd_lvl;
    opfetch = fetch;
    wr = wr_lvl;
    keys_in = take_bits(5);
    tape_read = take_bits(1);
    sd_dataout = take_bits(8);
    #1;
    seen_dout = dout;
    compare_value("dout", dout, expect_dout(addr, keys_in, tape_read, sd_dataout));
    compare_value("porthit", porthit, port_hit(addr[7:0]));
    compare_value("dataout", dataout, port_hit(addr[7:0]) && rd_lvl);
    compare_value("beeper_wr", beeper_wr, addr[7:0] == `ZP_PORT_FE && wr_s);
    compare_value("sd_start", sd_start, addr[7:0] == `ZP_PORT_SDDAT && (wr_s || rd_s));
    compare_value("sd_datain", sd_datain, wr_lvl ? d : 8'hFF);
    update_model(addr, d, wr_s, rd_s, fetch);
    @(negedge clk);
    check_registers();
  endtask

  function automatic logic [7:0] xt_write_index(input logic [2:0] sel);
    case (sel)
      3'd4:    return `ZP_XT_SYSCONF;
      3'd5:    return `ZP_XT_MEMCONF;
      3'd6:    return `ZP_XT_INTMASK;
      3'd7:    return `ZP_XT_CACHECONF;
      default: return `ZP_XT_RAMPAGE + {6'd0, sel[1:0]};
    endcase
  endfunction

  task automatic random_cycle();
    logic [2:0]  kind;
    logic [7:0]  hi;
    logic [7:0]  lo;
    logic [7:0]  d;
    logic [1:0]  dir;  // 1 write, 2 read, else idle
    logic        fetch;
    logic        rd_lvl;
    logic        wr_lvl;
    kind = take_bits(3);
    hi = take_bits(8);
    d = take_bits(8);
    dir = take_bits(2);
    fetch = 1'b0;
    case (kind)
      3'd0:
      begin
        hi = xt_write_index(take_bits(3));
        lo = `ZP_PORT_XT;
        dir = 2'd1;
      end
      3'd1:
      begin
        lo = `ZP_PORT_FD;
        d[5] = d[5] & take_bits(1);  // keep 48K lock rare
        dir = 2'd1;
      end
      3'd2:
      begin
        lo = `ZP_PORT_FE;
        dir = dir[0] ? 2'd1 : 2'd2;
      end
      3'd3:
      begin
        if (dir == 2'd0)
          hi = `ZP_XT_XSTAT;
        else if (dir != 2'd3)
          hi = `ZP_XT_RAMPAGE + 8'd1 + {6'd0, dir};  // readable pages 2 and 3
        lo = `ZP_PORT_XT;
        dir = 2'd2;
      end
      3'd4:
      begin
        lo = `ZP_PORT_SDCFG;
        dir = 2'd1;
      end
      3'd5:
      begin
        lo = `ZP_PORT_SDDAT;
        dir = dir[0] ? 2'd1 : 2'd2;
      end
      3'd6:
      begin
        lo = take_bits(8);
        dir = 2'd0;
        fetch = 1'b1;  // opcode fetch between port cycles
      end
      default:
        lo = take_bits(8);
    endcase
    rd_lvl = take_bits(1);
    wr_lvl = take_bits(1);
    run_cycle({hi, lo}, d, dir == 2'd1, dir == 2'd2, rd_lvl, fetch, wr_lvl);
  endtask

  initial
  begin
    logic [7:0] mode_byte;
    for (int phase = 0; phase < num_phases; phase++)
    begin
      apply_reset();
      check_registers();
      compare_value("xt_page after reset", xt_page, 32'h0002_0500);
      compare_value("memconf after reset", memconf, 8'h04);
      compare_value("intmask after reset", intmask, 8'h01);
      compare_value("spi_cs_n after reset", spi_cs_n, 4'hF);
      for (int i = 0; i < 3; i++)
      begin
        run_cycle({`ZP_XT_XSTAT, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        compare_value("xstat power-up bit", seen_dout[6], i == 1);
      end
      mode_byte = take_bits(8);
      mode_byte[7:6] = phase[1:0];  // each 128K lock mode in turn
      run_cycle({`ZP_XT_MEMCONF, `ZP_PORT_XT}, mode_byte, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
      repeat (ops_per_phase) random_cycle();
    end
    if (fail_count == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial
  begin
    #(num_ops * 20 * clk_period);
    $display("watchdog expired, the test did not finish in time");
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: zports_top.sv
// top of the I/O port block; connects decode, registers, SD port and read mux
`timescale 1ns/1ns
`default_nettype none

module zports_top
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire zports_pkg::data_t      din,
  input  wire [15:0]                  a,
  input  wire                         iord,
  input  wire                         iowr_s,
  input  wire                         iord_s,
  input  wire                         opfetch,
  input  wire                         wr,
  input  wire [4:0]                   keys_in,
  input  wire                         tape_read,
  input  wire zports_pkg::data_t      sd_dataout,
  output wire zports_pkg::data_t      dout,
  output wire                         porthit,
  output wire                         dataout,
  output wire                         beeper_wr,
  output wire zports_pkg::xt_page_t   xt_page,
  output wire zports_pkg::data_t      sysconf,
  output wire zports_pkg::data_t      memconf,
  output wire [3:0]                   cacheconf,
  output wire zports_pkg::data_t      intmask,
  output wire zports_pkg::spi_cs_t    spi_cs_n,
  output wire                         sd_start,
  output wire zports_pkg::data_t      sd_datain
);

  wire zports_pkg::io_strobe_t strobes;
  wire                         lock48;
  wire                         pwr_up_bit;

  assign beeper_wr = strobes.fe_wr;

  port_decode decode_i (.a(a), .iord(iord), .iowr_s(iowr_s), .iord_s(iord_s),
    .lock48(lock48), .strobes(strobes), .porthit(porthit), .dataout(dataout));

  config_regs regs_i (.clk(clk), .rst(rst), .hoa(a[15:8]), .din(din), .opfetch(opfetch),
    .strobes(strobes), .xt_page(xt_page), .sysconf(sysconf), .memconf(memconf),
    .intmask(intmask), .cacheconf(cacheconf), .lock48(lock48), .pwr_up_bit(pwr_up_bit));

  sd_port sd_i (.clk(clk), .rst(rst), .din(din), .wr(wr), .strobes(strobes),
    .spi_cs_n(spi_cs_n), .sd_start(sd_start), .sd_datain(sd_datain));

  port_read_mux mux_i (.a(a), .keys_in(keys_in), .tape_read(tape_read),
    .sd_dataout(sd_dataout), .xt_page(xt_page), .pwr_up_bit(pwr_up_bit), .dout(dout));

endmodule

`default_nettype wire

// File: port_read_mux.sv
// read data selection for FE, AF, 77 and 57; the result goes to the Z80 data bus
`timescale 1ns/1ns
`default_nettype none
`include "zports_consts.svh"

module port_read_mux
(
  input  wire [15:0]                a,
  input  wire [4:0]                 keys_in,
  input  wire                       tape_read,
  input  wire zports_pkg::data_t    sd_dataout,
  input  wire zports_pkg::xt_page_t xt_page,
  input  wire                       pwr_up_bit,
  output zports_pkg::data_t         dout
);

  zports_pkg::port_addr_t loa;
  zports_pkg::port_addr_t hoa;

  assign loa = a[7:0];
  assign hoa = a[15:8];

  always_comb
  begin
    case (loa)
      `ZP_PORT_FE:
        dout = {1'b1, tape_read, 1'b1, keys_in};
      `ZP_PORT_XT:
        case (hoa)
          `ZP_XT_XSTAT:
            dout = {1'b0, pwr_up_bit, 3'b000, `ZP_VDAC_VER};
          `ZP_XT_RAMPAGE + 8'd2:
            dout = xt_page[23:16];
          `ZP_XT_RAMPAGE + 8'd3:
            dout = xt_page[31:24];
          default:
            dout = `ZP_FLOAT_BYTE;  // write-only registers
        endcase
      `ZP_PORT_SDCFG:
        dout = `ZP_SDCFG_STATUS;
      `ZP_PORT_SDDAT:
        dout = sd_dataout;  // byte from the last transfer
      default:
        dout = `ZP_FLOAT_BYTE;
    endcase
  end

endmodule

`default_nettype wire

// File: sd_port.sv
// SD card ports 77/57; holds the spi chip selects and feeds the external spi engine
`timescale 1ns/1ns
`default_nettype none
`include "zports_consts.svh"

module sd_port
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire zports_pkg::data_t      din,
  input  wire                         wr,
  input  wire zports_pkg::io_strobe_t strobes,
  output zports_pkg::spi_cs_t         spi_cs_n,
  output wire                         sd_start,
  output zports_pkg::data_t           sd_datain
);

  // bit 1 is the sd select as written, the others are active high in din
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      spi_cs_n <= `ZP_RST_SPI_CS;
    else if (strobes.sdcfg_wr)
      spi_cs_n <= {~din[4:2], din[1]};
  end

  // one byte per 57 access
  assign sd_start = strobes.sd_xfer;

  // reads shift out ones
  always_comb
  begin
    if (wr)
      sd_datain = din;
    else
      sd_datain = `ZP_FLOAT_BYTE;
  end

endmodule

`default_nettype wire

// File: config_regs.sv
// XT window registers, 7FFD paging with the 48K/128K locks and the power-up status bit
`timescale 1ns/1ns
`default_nettype none
`include "zports_consts.svh"

module config_regs
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire zports_pkg::port_addr_t hoa,
  input  wire zports_pkg::data_t      din,
  input  wire                         opfetch,
  input  wire zports_pkg::io_strobe_t strobes,
  output zports_pkg::xt_page_t        xt_page,
  output zports_pkg::data_t           sysconf,
  output zports_pkg::data_t           memconf,
  output zports_pkg::data_t           intmask,
  output logic [3:0]                  cacheconf,
  output logic                        lock48,
  output logic                        pwr_up_bit
);

  localparam zports_pkg::port_addr_t rampage_base = `ZP_XT_RAMPAGE;

  zports_pkg::page_t rampage [0:3];
  zports_pkg::page_t page3_new;

  logic m1_lock128;  // lock decision taken at the last opcode fetch
  logic pwr_up;      // set until the first XSTAT read
  logic lock128_2;
  logic lock128_3;
  logic lock128;

  // MEMCONF 7:6 picks the 128K lock mode
  assign lock128_2 = (memconf[7:6] == 2'b10);
  assign lock128_3 = (memconf[7:6] == 2'b11);
  assign lock128   = lock128_2 ? m1_lock128 : memconf[6];

  // mode 3 gives three extra page bits, else two unless locked
  assign page3_new = lock128_3 ? {2'b00, din[5], din[7:6], din[2:0]}
                               : {3'b000, (lock128 ? 2'b00 : din[7:6]), din[2:0]};

  assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sysconf    <= `ZP_RST_SYSCONF;
      memconf    <= `ZP_RST_MEMCONF;
      intmask    <= `ZP_RST_INTMASK;
      cacheconf  <= `ZP_RST_CACHECONF;
      rampage[0] <= `ZP_RST_PAGE0;
      rampage[1] <= `ZP_RST_PAGE1;
      rampage[2] <= `ZP_RST_PAGE2;
      rampage[3] <= `ZP_RST_PAGE3;
    end
    else if (strobes.p7ffd_wr)
    begin
      memconf[0] <= din[4];  // rom select
      rampage[3] <= page3_new;
    end
    else if (strobes.xt_wr)
    begin
      if (hoa[7:2] == rampage_base[7:2])
        rampage[hoa[1:0]] <= din;
      if (hoa == `ZP_XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {4{din[2]}};  // turbo bit enables all cache windows
      end
      if (hoa == `ZP_XT_CACHECONF)
        cacheconf <= din[3:0];
      if (hoa == `ZP_XT_MEMCONF)
        memconf <= din;
      if (hoa == `ZP_XT_INTMASK)
        intmask <= din;
    end
  end

  // equal bits 7:6 on the fetched opcode mean locked
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      m1_lock128 <= 1'b0;
    else if (opfetch)
      m1_lock128 <= !(din[7] ^ din[6]);
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (strobes.p7ffd_wr && !lock128_3)
      lock48 <= din[5];  // bit 5 is a page bit in mode 3
  end

  // XSTAT read shows the flag from before the read
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pwr_up     <= 1'b1;
      pwr_up_bit <= 1'b0;
    end
    else if (strobes.xt_rd && (hoa == `ZP_XT_XSTAT))
    begin
      pwr_up_bit <= pwr_up;
      pwr_up     <= 1'b0;
    end
  end

  memconf_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(memconf))
    else $error("memconf unknown out of reset");

endmodule

`default_nettype wire

// File: port_decode.sv
// low address byte decoder; gives porthit, dataout and the strobe struct for the register blocks
`timescale 1ns/1ns
`default_nettype none
`include "zports_consts.svh"

module port_decode
(
  input  wire [15:0]              a,
  input  wire                     iord,
  input  wire                     iowr_s,
  input  wire                     iord_s,
  input  wire                     lock48,
  output zports_pkg::io_strobe_t  strobes,
  output wire                     porthit,
  output wire                     dataout
);

  zports_pkg::port_addr_t loa;

  logic hit_fe;
  logic hit_fd;
  logic hit_xt;
  logic hit_sdcfg;
  logic hit_sddat;

  assign loa = a[7:0];

  always_comb
  begin
    hit_fe    = (loa == `ZP_PORT_FE);
    hit_fd    = (loa == `ZP_PORT_FD);
    hit_xt    = (loa == `ZP_PORT_XT);
    hit_sdcfg = (loa == `ZP_PORT_SDCFG);
    hit_sddat = (loa == `ZP_PORT_SDDAT);
  end

  // FD is claimed whatever the high byte, a[15] only picks 7FFD
  assign porthit = hit_fe || hit_fd || hit_xt || hit_sdcfg || hit_sddat;

  // drive the data bus only on an internal read
  assign dataout = porthit && iord;

  always_comb
  begin
    strobes.fe_wr    = hit_fe && iowr_s;
    strobes.xt_wr    = hit_xt && iowr_s;
    strobes.xt_rd    = hit_xt && iord_s;
    // once the 48K lock is set, 7FFD writes are dropped here
    strobes.p7ffd_wr = hit_fd && !a[15] && iowr_s && !lock48;
    strobes.sdcfg_wr = hit_sdcfg && iowr_s;
    strobes.sd_xfer  = hit_sddat && (iowr_s || iord_s);  // both directions clock a byte
  end

  // sampled as the write strobe drops, so the values are those of the strobe cycle
  wr_strobes_exclusive: assert property (@(negedge iowr_s)
    $onehot0({strobes.fe_wr, strobes.xt_wr, strobes.p7ffd_wr,
              strobes.sdcfg_wr, strobes.sd_xfer}))
    else $error("more than one port write strobe at once");

endmodule

`default_nettype wire

// File: zports_pkg.sv
// shared types of the I/O port block; referenced by scoped name from every module
`default_nettype none

package zports_pkg;

  // one byte of the Z80 address bus
  typedef logic [7:0] port_addr_t;

  // one byte of the data bus
  typedef logic [7:0] data_t;

  // one 16K RAM page number
  typedef logic [7:0] page_t;

  // pages 3..0, page 3 in the top byte
  typedef logic [31:0] xt_page_t;

  // active low selects, bit 0 sd, then ft, sd2, esp
  typedef logic [3:0] spi_cs_t;

  // single cycle pulses in the clk domain, one per decoded access
  typedef struct packed {
    logic fe_wr;     // FE write, beeper and border
    logic xt_wr;     // AF window write
    logic xt_rd;     // AF window read
    logic p7ffd_wr;  // 7FFD write that passed the 48K lock
    logic sdcfg_wr;  // 77 write
    logic sd_xfer;   // 57 read or write starts a spi byte
  } io_strobe_t;

endpackage

`default_nettype wire

// File: zports_consts.svh
// port numbers, XT register indices and reset values, included by the port blocks
`ifndef ZPORTS_CONSTS_SVH
`define ZPORTS_CONSTS_SVH

// low address byte of each decoded port
`define ZP_PORT_FE        8'hFE   // keyboard, tape in, beeper
`define ZP_PORT_FD        8'hFD   // 7FFD paging when a[15] is low
`define ZP_PORT_XT        8'hAF   // extended register window
`define ZP_PORT_SDCFG     8'h77   // sd chip selects
`define ZP_PORT_SDDAT     8'h57   // spi data

// register index inside the AF window, taken from a[15:8]
`define ZP_XT_XSTAT       8'h00   // read side only
`define ZP_XT_RAMPAGE     8'h10   // four pages at 10..13
`define ZP_XT_SYSCONF     8'h20
`define ZP_XT_MEMCONF     8'h21
`define ZP_XT_INTMASK     8'h2A
`define ZP_XT_CACHECONF   8'h2B

// values loaded at reset
`define ZP_RST_SYSCONF    8'h00   // 3.5 MHz
`define ZP_RST_MEMCONF    8'h04   // rom mapped, no lock
`define ZP_RST_INTMASK    8'h01   // frame int only
`define ZP_RST_CACHECONF  4'h0
`define ZP_RST_PAGE0      8'h00
`define ZP_RST_PAGE1      8'h05
`define ZP_RST_PAGE2      8'h02
`define ZP_RST_PAGE3      8'h00

// spi chip selects all released
`define ZP_RST_SPI_CS     4'hF

// constant board version shown in XSTAT bits 2:0
`define ZP_VDAC_VER       3'h7

// read value of an undecoded port or register
`define ZP_FLOAT_BYTE     8'hFF

// 77 read is fixed, card present and writable
`define ZP_SDCFG_STATUS   8'h00

`endif
